// File: design/ps2_frame_pkg.sv
// line level of the PS/2 device-to-host link
package ps2_frame_pkg;

	// start + 8 data + parity + stop
	localparam int frame_bits = 11;

	// frame layout, bit 0 is the first bit on the wire
	//   [0]    start, always 0
	//   [8:1]  data, lsb first
	//   [9]    odd parity over data
	//   [10]   stop, always 1

	// one checked byte from the receiver
	typedef struct packed {
		logic [7:0] data;  // scan code byte as sent
		logic       valid; // one-cycle strobe
	} rx_byte_t;

endpackage

// File: design/key_event_pkg.sv
// scan code set 2 values and the key event that runs down the chain
package key_event_pkg;

	// prefix bytes
	localparam logic [7:0] sc_extend = 8'hE0; // extended key follows
	localparam logic [7:0] sc_break  = 8'hF0; // key release follows

	// modifier make codes
	localparam logic [7:0] sc_lshift = 8'h12;
	localparam logic [7:0] sc_rshift = 8'h59;
	localparam logic [7:0] sc_caps   = 8'h58;

	// 0 means no printable character
	typedef logic [7:0] ascii_t;

	// one make or break of a key
	typedef struct packed {
		logic       released; // break code
		logic       extended; // came after E0
		logic [7:0] scan;     // scan code without prefixes
		ascii_t     ascii;    // filled in by ascii_map
	} key_event_t;

endpackage

// File: design/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx #(
	parameter int timeout_cycles = 10000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ps2_clk,
	input  logic                    ps2_data,
	output ps2_frame_pkg::rx_byte_t byte_out,
	output logic                    frame_error
);

	localparam int last_bit = ps2_frame_pkg::frame_bits - 1;
	localparam int cnt_w    = $clog2(ps2_frame_pkg::frame_bits);
	localparam int idle_w   = $clog2(timeout_cycles + 1);

	logic [1:0]        clk_sync;  // [0] is pin side
	logic [1:0]        data_sync;
	logic              clk_prev;  // synced clock one cycle back
	logic              fall;      // synced clock went 1 -> 0
	logic              fall_q;    // registered edge strobe
	logic              data_q;    // data level taken at the edge
	logic [cnt_w-1:0]  bit_cnt;   // bits already in shreg
	logic [idle_w-1:0] idle_cnt;  // clocks since last edge
	logic [last_bit:0] shreg;
	logic [last_bit:0] frame;     // shreg with the current bit shifted in
	logic              last_edge; // edge of the stop bit
	logic              frame_ok;
	logic [7:0]        byte_q;
	logic              byte_vld;

	// lines idle high, so reset to 1 to avoid a false edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
			fall_q    <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
			fall_q    <= fall;
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// data is stable while the device holds the clock low
	always_ff @(posedge clk) begin
		if (fall)
			data_q <= data_sync[1];
	end

	// lsb first on the wire, shift right so bit 0 ends up as start
	assign frame     = {data_q, shreg[last_bit:1]};
	assign last_edge = fall_q && (bit_cnt == cnt_w'(last_bit));
	assign frame_ok  = ~frame[0] & frame[last_bit] & (^frame[last_bit-1:1]); // odd parity

	always_ff @(posedge clk) begin
		if (fall_q)
			shreg <= frame;
		if (last_edge)
			byte_q <= frame[8:1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt     <= '0;
			idle_cnt    <= '0;
			byte_vld    <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_vld    <= 1'b0; // strobes
			frame_error <= 1'b0;
			if (fall_q) begin
				idle_cnt <= '0;
				if (last_edge) begin
					bit_cnt     <= '0;
					byte_vld    <= frame_ok;
					frame_error <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (bit_cnt != '0) begin
				// stalled mid frame, drop it quietly
				if (idle_cnt == idle_w'(timeout_cycles - 1)) begin
					bit_cnt  <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	assign byte_out = '{data: byte_q, valid: byte_vld};

	a_bit_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		bit_cnt <= cnt_w'(last_bit));

	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(byte_vld && frame_error));

endmodule

// File: design/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder (
	input  logic                       clk,
	input  logic                       rst_n,
	input  ps2_frame_pkg::rx_byte_t    byte_in,
	output key_event_pkg::key_event_t  raw_event,
	output logic                       raw_valid,
	output logic                       shift,
	output logic                       caps
);

	logic pending_extend; // E0 seen, waiting for the key byte
	logic pending_break;  // F0 seen
	logic lshift_q;
	logic rshift_q;
	logic caps_q;
	logic is_prefix;
	logic key_byte;       // strobe for a non-prefix byte

	assign is_prefix = (byte_in.data == key_event_pkg::sc_extend) ||
		(byte_in.data == key_event_pkg::sc_break);
	assign key_byte  = byte_in.valid & ~is_prefix;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_extend <= 1'b0;
			pending_break  <= 1'b0;
			lshift_q       <= 1'b0;
			rshift_q       <= 1'b0;
			caps_q         <= 1'b0;
			raw_valid      <= 1'b0;
		end else begin
			raw_valid <= key_byte; // prefixes give no event
			if (byte_in.valid) begin
				if (byte_in.data == key_event_pkg::sc_extend) begin
					pending_extend <= 1'b1;
				end else if (byte_in.data == key_event_pkg::sc_break) begin
					pending_break <= 1'b1;
				end else begin
					pending_extend <= 1'b0;
					pending_break  <= 1'b0;
					// E0 12 shows up in print screen, not a real shift
					if (!pending_extend) begin
						case (byte_in.data)
							key_event_pkg::sc_lshift: lshift_q <= ~pending_break;
							key_event_pkg::sc_rshift: rshift_q <= ~pending_break;
							key_event_pkg::sc_caps: begin
								if (!pending_break)
									caps_q <= ~caps_q; // toggle on make only
							end
							default: ;
						endcase
					end
				end
			end
		end
	end

	// ascii gets filled downstream
	always_ff @(posedge clk) begin
		if (key_byte)
			raw_event <= '{
				released: pending_break,
				extended: pending_extend,
				scan:     byte_in.data,
				ascii:    '0
			};
	end

	assign shift = lshift_q | rshift_q; // either side holds shift
	assign caps  = caps_q;

	a_valid_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
		raw_valid |-> $past(byte_in.valid));

endmodule

// File: design/ascii_map.sv
`timescale 1ns/1ps

module ascii_map (
	input  logic                      clk,
	input  logic                      rst_n,
	input  key_event_pkg::key_event_t event_in,
	input  logic                      event_valid,
	input  logic                      shift,
	input  logic                      caps,
	output key_event_pkg::key_event_t event_out,
	output logic                      event_out_valid
);

	key_event_pkg::ascii_t ltr;   // lower case letter, else 0
	logic [15:0]           pair;  // {plain, shifted}, else 0
	key_event_pkg::ascii_t fixed; // keys with no shifted form
	key_event_pkg::ascii_t ascii_nx;

	always_comb begin
		ltr   = '0;
		pair  = '0;
		fixed = '0;
		case (event_in.scan)
			8'h1C: ltr = "a";
			8'h32: ltr = "b";
			8'h21: ltr = "c";
			8'h23: ltr = "d";
			8'h24: ltr = "e";
			8'h2B: ltr = "f";
			8'h34: ltr = "g";
			8'h33: ltr = "h";
			8'h43: ltr = "i";
			8'h3B: ltr = "j";
			8'h42: ltr = "k";
			8'h4B: ltr = "l";
			8'h3A: ltr = "m";
			8'h31: ltr = "n";
			8'h44: ltr = "o";
			8'h4D: ltr = "p";
			8'h15: ltr = "q";
			8'h2D: ltr = "r";
			8'h1B: ltr = "s";
			8'h2C: ltr = "t";
			8'h3C: ltr = "u";
			8'h2A: ltr = "v";
			8'h1D: ltr = "w";
			8'h22: ltr = "x";
			8'h35: ltr = "y";
			8'h1A: ltr = "z";
			// digit row, us layout
			8'h16: pair = "1!";
			8'h1E: pair = "2@";
			8'h26: pair = "3#";
			8'h25: pair = "4$";
			8'h2E: pair = "5%";
			8'h36: pair = "6^";
			8'h3D: pair = "7&";
			8'h3E: pair = "8*";
			8'h46: pair = "9(";
			8'h45: pair = "0)";
			// punctuation
			8'h0E: pair = {8'h60, "~"}; // backtick key
			8'h4E: pair = "-_";
			8'h55: pair = "=+";
			8'h54: pair = "[{";
			8'h5B: pair = "]}";
			8'h5D: pair = "\\|";
			8'h4C: pair = ";:";
			8'h52: pair = "'\"";
			8'h41: pair = ",<";
			8'h49: pair = ".>";
			8'h4A: pair = "/?";
			// control keys
			8'h29: fixed = 8'h20; // space
			8'h66: fixed = 8'h08; // backspace
			8'h5A: fixed = 8'h0D; // enter
			8'h76: fixed = 8'h1B; // escape
			default: ; // modifiers and unmapped stay 0
		endcase

		if (event_in.extended)
			ascii_nx = '0; // arrows, keypad enter etc
		else if (ltr != '0)
			ascii_nx = (shift ^ caps) ? ltr - 8'h20 : ltr; // caps hits letters only
		else if (pair != '0)
			ascii_nx = shift ? pair[7:0] : pair[15:8];
		else
			ascii_nx = fixed;
	end

	always_ff @(posedge clk) begin
		if (event_valid)
			event_out <= '{
				released: event_in.released,
				extended: event_in.extended,
				scan:     event_in.scan,
				ascii:    ascii_nx
			};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			event_out_valid <= 1'b0;
		else
			event_out_valid <= event_valid;
	end

endmodule

// File: design/key_out_port.sv
`timescale 1ns/1ps

module key_out_port #(
	parameter int queue_depth = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  key_event_pkg::key_event_t event_in,
	input  logic                      event_valid,
	output key_event_pkg::key_event_t key_event,
	output logic                      req,
	input  logic                      ack,
	output logic                      overrun
);

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	typedef enum logic {
		st_idle,
		st_req
	} hs_state_t;

	key_event_pkg::key_event_t mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	hs_state_t        state;
	logic             full;
	logic             push;
	logic             pop;

	// wrap for any depth, not only powers of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == cnt_w'(queue_depth));
	assign push = event_valid & ~full;        // ps2 can't wait, drop when full
	assign pop  = (state == st_req) & ack;    // host took the head entry

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= event_in;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			state   <= st_idle;
			overrun <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + cnt_w'(push) - cnt_w'(pop);
			if (event_valid && full)
				overrun <= 1'b1; // sticky
			case (state)
				// raise req with the entry landing this edge as well
				st_idle: if (!ack && (count != '0 || push)) state <= st_req;
				st_req:  if (ack) state <= st_idle; // pop and drop req
				default: state <= st_idle;
			endcase
		end
	end

	assign req       = (state == st_req);
	assign key_event = mem[rd_ptr]; // head of queue

	a_event_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req |=> !req || $stable(key_event));

	a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req) |-> !$past(ack));

endmodule

// File: design/ps2_keyboard.sv
`timescale 1ns/1ps

module ps2_keyboard #(
	parameter int timeout_cycles = 10000, // about 200 us at 50 MHz
	parameter int queue_depth    = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ps2_clk,   // async from pin
	input  logic                      ps2_data,  // async from pin
	output key_event_pkg::key_event_t key_event,
	output logic                      req,
	input  logic                      ack,
	output logic                      overrun,
	output logic                      frame_error
);

	ps2_frame_pkg::rx_byte_t   rx_byte;
	key_event_pkg::key_event_t raw_event;
	logic                      raw_valid;
	logic                      shift;
	logic                      caps;
	key_event_pkg::key_event_t map_event;
	logic                      map_valid;

	// pins to checked bytes
	ps2_rx #(
		.timeout_cycles(timeout_cycles)
	) i_ps2_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_out   (rx_byte),
		.frame_error(frame_error)
	);

	// bytes to key events plus modifier state
	scan_decoder i_scan_decoder (
		.clk      (clk),
		.rst_n    (rst_n),
		.byte_in  (rx_byte),
		.raw_event(raw_event),
		.raw_valid(raw_valid),
		.shift    (shift),
		.caps     (caps)
	);

	ascii_map i_ascii_map (
		.clk            (clk),
		.rst_n          (rst_n),
		.event_in       (raw_event),
		.event_valid    (raw_valid),
		.shift          (shift),
		.caps           (caps),
		.event_out      (map_event),
		.event_out_valid(map_valid)
	);

	// queue and host req/ack
	key_out_port #(
		.queue_depth(queue_depth)
	) i_key_out_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.event_in   (map_event),
		.event_valid(map_valid),
		.key_event  (key_event),
		.req        (req),
		.ack        (ack),
		.overrun    (overrun)
	);

endmodule

// File: test/ps2_keyboard_tb.sv
`timescale 1ns/1ps

module ps2_keyboard_tb;

	localparam int half_ps2   = 8; // system clocks per ps2 clock phase
	localparam int frame_clks = 2 * half_ps2 * (ps2_frame_pkg::frame_bits + 1);
	localparam int max_cycles = 6 * 12 * frame_clks + 2000; // 6 tests, up to 12 frames each

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic                      ps2_clk;
	logic                      ps2_data;
	logic                      ack;
	key_event_pkg::key_event_t key_event;
	logic                      req;
	logic                      overrun;
	logic                      frame_error;

	int    errors          = 0;
	int    tests           = 0;
	int    errors_at_start = 0;
	int    fe_seen         = 0; // frame_error pulses so far
	int    cycles          = 0;
	string test_name;

	ps2_keyboard #(
		.timeout_cycles(200),
		.queue_depth   (4)
	) i_ps2_keyboard (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.key_event  (key_event),
		.req        (req),
		.ack        (ack),
		.overrun    (overrun),
		.frame_error(frame_error)
	);

	always #5 clk = ~clk; // 10 ns

	always @(posedge clk) begin
		cycles++;
		if (rst_n && frame_error)
			fe_seen++;
		if (cycles >= max_cycles) begin
			$display("timeout: run went past %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// us layout, only the keys the tests press
	function automatic key_event_pkg::ascii_t key_ascii(input logic [7:0] scan,
		input logic shifted, input logic caps_on);
		case (scan)
			8'h1C: key_ascii = (shifted != caps_on) ? "A" : "a";
			8'h32: key_ascii = (shifted != caps_on) ? "B" : "b";
			8'h21: key_ascii = (shifted != caps_on) ? "C" : "c";
			8'h23: key_ascii = (shifted != caps_on) ? "D" : "d";
			8'h24: key_ascii = (shifted != caps_on) ? "E" : "e";
			8'h2B: key_ascii = (shifted != caps_on) ? "F" : "f";
			8'h16: key_ascii = shifted ? "!" : "1"; // caps ignored
			default: key_ascii = 8'h00; // modifiers
		endcase
	endfunction

	function automatic key_event_pkg::key_event_t key_ev(input logic released,
		input logic extended, input logic [7:0] scan, input logic shifted, input logic caps_on);
		key_event_pkg::key_event_t ev;
		ev.released = released;
		ev.extended = extended;
		ev.scan     = scan;
		ev.ascii    = extended ? 8'h00 : key_ascii(scan, shifted, caps_on); // no ascii for E0 keys
		return ev;
	endfunction

	// one event as text for error lines
	function automatic string event_str(input key_event_pkg::key_event_t ev);
		return $sformatf("rel %0b ext %0b scan %h ascii %h",
			ev.released, ev.extended, ev.scan, ev.ascii);
	endfunction

	task automatic clocks(input int n);
		repeat (n) begin
			@(posedge clk);
			#1; // drive just after the edge
		end
	endtask

	// device changes data while clock is high, host samples on the fall
	task automatic send_bits(input logic [10:0] bits, input int n);
		int i;
		for (i = 0; i < n; i++) begin
			ps2_data = bits[i];
			clocks(half_ps2);
			ps2_clk = 1'b0;
			clocks(half_ps2);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1; // idle
		clocks(2 * half_ps2);
	endtask

	task automatic send_frame(input logic [7:0] data, input bit bad_parity);
		send_bits({1'b1, (~^data) ^ bad_parity, data, 1'b0}, ps2_frame_pkg::frame_bits);
	endtask

	task automatic send_partial(input logic [7:0] data);
		send_bits({1'b1, ~^data, data, 1'b0}, 5); // device gives up after 5 bits
	endtask

	task automatic wait_req(input int budget, output bit ok);
		int n;
		n = 0;
		while (!req && n < budget) begin
			clocks(1);
			n++;
		end
		ok = req;
	endtask

	// one full four-phase cycle on the host side
	task automatic take_event(output key_event_pkg::key_event_t ev, output bit ok);
		int n;
		wait_req(2 * frame_clks, ok);
		if (!ok)
			return;
		ev  = key_event;
		ack = 1'b1;
		n   = 0;
		while (req && n < 10) begin // port pops then drops req
			clocks(1);
			n++;
		end
		assert (!req) else begin
			$display("%s: req still high 10 clocks after ack", test_name);
			errors++;
		end
		clocks(1);
		assert (!req) else begin
			$display("%s: req high again while ack still high", test_name);
			errors++;
		end
		ack = 1'b0;
		clocks(1);
	endtask

	task automatic expect_event(input key_event_pkg::key_event_t exp);
		key_event_pkg::key_event_t got;
		bit                        ok;
		take_event(got, ok);
		assert (ok) else begin
			$display("%s: no req for scan %h within the wait budget", test_name, exp.scan);
			errors++;
		end
		if (ok)
			assert (got == exp) else begin
				$display("MISMATCH %s: expected %s, actual %s", test_name,
					event_str(exp), event_str(got));
				errors++;
			end
	endtask

	task automatic expect_quiet(input int budget, input string what);
		bit ok;
		wait_req(budget, ok);
		assert (!ok) else begin
			$display("%s: req rose, %s", test_name, what);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s finished, %0d errors", test_name, errors - errors_at_start);
	endtask

	task automatic test_make_break();
		start_test("make_break");
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 0, 0)); // 'a'
		send_frame(8'hF0, 0);
		send_frame(8'h1C, 0);
		expect_event(key_ev(1, 0, 8'h1C, 0, 0));
		end_test();
	endtask

	task automatic test_shift();
		start_test("shift");
		send_frame(8'h12, 0);
		expect_event(key_ev(0, 0, 8'h12, 1, 0)); // shift itself, ascii 0
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 1, 0));
		send_frame(8'h16, 0);
		expect_event(key_ev(0, 0, 8'h16, 1, 0)); // '!'
		send_frame(8'hF0, 0);
		send_frame(8'h12, 0);
		expect_event(key_ev(1, 0, 8'h12, 0, 0));
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 0, 0));
		end_test();
	endtask

	task automatic test_caps_lock();
		start_test("caps_lock");
		send_frame(8'h58, 0);
		expect_event(key_ev(0, 0, 8'h58, 0, 1));
		send_frame(8'hF0, 0);
		send_frame(8'h58, 0);
		expect_event(key_ev(1, 0, 8'h58, 0, 1)); // break leaves caps on
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 0, 1)); // 'A'
		send_frame(8'h16, 0);
		expect_event(key_ev(0, 0, 8'h16, 0, 1)); // digit stays '1'
		send_frame(8'h58, 0);
		expect_event(key_ev(0, 0, 8'h58, 0, 0));
		send_frame(8'hF0, 0);
		send_frame(8'h58, 0);
		expect_event(key_ev(1, 0, 8'h58, 0, 0));
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 0, 0));
		end_test();
	endtask

	task automatic test_extended();
		start_test("extended");
		send_frame(8'hE0, 0);
		expect_quiet(30, "event for an E0 prefix alone");
		send_frame(8'h74, 0);
		expect_event(key_ev(0, 1, 8'h74, 0, 0)); // right arrow
		send_frame(8'hE0, 0);
		send_frame(8'hF0, 0);
		expect_quiet(30, "event for E0 F0 prefixes alone");
		send_frame(8'h74, 0);
		expect_event(key_ev(1, 1, 8'h74, 0, 0));
		send_frame(8'hE0, 0);
		send_frame(8'h5A, 0);
		expect_event(key_ev(0, 1, 8'h5A, 0, 0)); // keypad enter, plain 5A is 0D
		end_test();
	endtask

	task automatic test_line_errors();
		int fe_before;
		start_test("line_errors");
		fe_before = fe_seen;
		send_frame(8'h1C, 1); // parity flipped
		assert (fe_seen == fe_before + 1) else begin
			$display("%s: %0d frame_error pulses for one bad parity frame",
				test_name, fe_seen - fe_before);
			errors++;
		end
		expect_quiet(30, "event for a frame with bad parity");
		send_partial(8'h1C);
		clocks(300); // longer than the 200 clock timeout
		send_frame(8'h1C, 0);
		expect_event(key_ev(0, 0, 8'h1C, 0, 0));
		end_test();
	endtask

	task automatic test_back_pressure();
		logic [7:0] keys [6];
		int         i;
		keys = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B}; // a..f
		start_test("back_pressure");
		assert (!overrun) else begin
			$display("%s: overrun set before the queue filled", test_name);
			errors++;
		end
		for (i = 0; i < 6; i++)
			send_frame(keys[i], 0); // ack withheld, queue holds 4
		assert (overrun) else begin
			$display("%s: overrun low after six events into a queue of four", test_name);
			errors++;
		end
		for (i = 0; i < 4; i++)
			expect_event(key_ev(0, 0, keys[i], 0, 0));
		expect_quiet(40, "more than four events came out of the queue");
		end_test();
	endtask

	initial begin
		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		ack      = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		clocks(5);
		test_make_break();
		test_shift();
		test_caps_lock();
		test_extended();
		test_line_errors();
		test_back_pressure();
		$display("summary: %0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: ps2_keyboard.f
design/ps2_frame_pkg.sv
design/key_event_pkg.sv
design/ps2_rx.sv
design/scan_decoder.sv
design/ascii_map.sv
design/key_out_port.sv
design/ps2_keyboard.sv
test/ps2_keyboard_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f ps2_keyboard.f \
	--top-module ps2_keyboard_tb -o ps2_keyboard_sim &&
./obj_dir/ps2_keyboard_sim | tee /dev/stderr | grep -q "^NO ERRORS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
